// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and constants.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [3:0]  bus_id_t;

    localparam addr_t   RESET_PC     = 32'h8000_0000;
    localparam bus_id_t FETCH_ID     = 4'd1;    // reads with any other id belong to the data side.
    localparam int      QUIET_CYCLES = 4;
    localparam addr_t   PC_STEP      = 32'd4;

    // holds the idle samples seen before the last one.
    typedef logic [$clog2(QUIET_CYCLES)-1:0] quiet_cnt_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // grouped signals.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic  taken;   // branch or jal target valid.
        logic  jalr;    // jalr resolved this cycle.
        addr_t target;
    } redirect_t;

    typedef struct packed {
        logic    done;
        bus_id_t id;
        instr_t  data;
    } rd_resp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machines.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        F_IDLE, F_QUIET1, F_QUIET2, F_QUIET3, F_REQ, F_WAIT, F_DONE
    } fetch_state_e;

    typedef enum logic [1:0] {
        MD_IDLE, MD_BUSY, MD_WAIT_FETCH, MD_RELEASE
    } md_state_e;

endpackage

`default_nettype wire

// ==== muldiv_hold.sv ====
`timescale 1ns/10ps
`default_nettype none

module muldiv_hold
    import core_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic md_start,
    input  logic md_done,
    input  logic fetch_done,
    output logic md_hold,
    output logic md_release
);

    md_state_e state;
    md_state_e state_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // the unit and the outstanding fetch may finish in either order.
    always_comb begin
        state_nxt = state;
        unique case (state)
            MD_IDLE: begin
                if (md_start) begin
                    state_nxt = MD_BUSY;
                end
            end
            MD_BUSY: begin
                if (md_done && fetch_done) begin
                    state_nxt = MD_RELEASE;    // both ended together.
                end else if (md_done) begin
                    state_nxt = MD_WAIT_FETCH;
                end
            end
            MD_WAIT_FETCH: begin
                if (fetch_done) begin
                    state_nxt = MD_RELEASE;
                end
            end
            MD_RELEASE: begin
                state_nxt = MD_IDLE;           // a single step of the pc.
            end
            default: begin
                state_nxt = MD_IDLE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs decoded from the state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign md_hold    = (state == MD_BUSY) || (state == MD_WAIT_FETCH);
    assign md_release = (state == MD_RELEASE);

endmodule

`default_nettype wire

// ==== fetch_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_ctrl
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     bus_idle,
    input  logic     ar_ready,
    input  rd_resp_t rd_resp,
    input  addr_t    curr_pc,
    output logic     ar_valid,
    output bus_id_t  ar_id,
    output addr_t    ar_addr,
    output instr_t   instr,
    output logic     instr_valid,
    output logic     fetch_done
);

    fetch_state_e state;
    fetch_state_e state_nxt;
    quiet_cnt_t   quiet_cnt;
    logic         counting;
    logic         quiet_met;
    logic         ar_hs;
    logic         resp_hit;
    logic         req_start;

    assign ar_hs     = ar_valid && ar_ready;
    assign resp_hit  = rd_resp.done && (rd_resp.id == FETCH_ID);
    assign counting  = (state == F_IDLE) || (state == F_QUIET1) ||
                       (state == F_QUIET2) || (state == F_QUIET3);
    assign quiet_met = bus_idle && (quiet_cnt == quiet_cnt_t'(QUIET_CYCLES - 1));
    assign req_start = (state != F_REQ) && (state_nxt == F_REQ);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus quiet counter.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // any busy sample restarts the count from zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quiet_cnt <= '0;
        end else if (counting && bus_idle && !quiet_met) begin
            quiet_cnt <= quiet_cnt + quiet_cnt_t'(1);
        end else begin
            quiet_cnt <= '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read request state machine.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= F_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            F_IDLE, F_QUIET1, F_QUIET2, F_QUIET3: begin
                if (!bus_idle) begin
                    state_nxt = F_IDLE;
                end else if (quiet_met) begin
                    state_nxt = F_REQ;
                end else if (state == F_IDLE) begin
                    state_nxt = F_QUIET1;
                end else if (state == F_QUIET1) begin
                    state_nxt = F_QUIET2;
                end else begin
                    state_nxt = F_QUIET3;
                end
            end
            F_REQ: begin
                if (ar_hs) begin
                    state_nxt = F_WAIT;        // address beat taken.
                end
            end
            F_WAIT: begin
                if (resp_hit) begin
                    state_nxt = F_DONE;        // data reads in flight are skipped.
                end
            end
            F_DONE: begin
                state_nxt = F_IDLE;
            end
            default: begin
                state_nxt = F_IDLE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registered bus and decode outputs.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid    <= 1'b0;
            ar_id       <= '0;
            instr       <= '0;
            instr_valid <= 1'b0;
        end else begin
            ar_valid    <= (state_nxt == F_REQ);  // stays up under back-pressure.
            ar_id       <= (state_nxt == F_REQ) ? FETCH_ID : '0;
            instr_valid <= (state_nxt == F_DONE);
            if ((state == F_WAIT) && resp_hit) begin
                instr <= rd_resp.data;
            end
        end
    end

    // the address is frozen at the request so a moving pc cannot disturb the beat.
    always_ff @(posedge clk) begin
        if (req_start) begin
            ar_addr <= curr_pc;
        end
    end

    assign fetch_done = (state == F_DONE);

endmodule

`default_nettype wire

// ==== pc_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_gen
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  redirect_t redirect,
    input  logic      mem_stall,
    input  logic      md_hold,
    input  logic      md_release,
    input  logic      fetch_done,
    output addr_t     curr_pc
);

    addr_t pc_nxt;
    addr_t jalr_target;
    logic  jalr_pend;
    logic  load_jalr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next pc selection.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the arithmetic release outranks every other source.
    always_comb begin
        pc_nxt    = curr_pc;
        load_jalr = 1'b0;
        if (md_release) begin
            pc_nxt = curr_pc + PC_STEP;
        end else if (md_hold) begin
            pc_nxt = curr_pc;
        end else if (mem_stall) begin
            pc_nxt = curr_pc;
        end else if (redirect.jalr) begin
            pc_nxt = curr_pc;                // target goes to the latch first.
        end else if (jalr_pend) begin
            pc_nxt    = jalr_target;
            load_jalr = 1'b1;
        end else if (redirect.taken) begin
            pc_nxt = redirect.target;
        end else if (fetch_done) begin
            pc_nxt = curr_pc + PC_STEP;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program counter.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= RESET_PC;
        end else begin
            curr_pc <= pc_nxt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // delayed jalr.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the flag survives a hold and is cleared only once the target is loaded.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_pend <= 1'b0;
        end else if (redirect.jalr) begin
            jalr_pend <= 1'b1;
        end else if (load_jalr) begin
            jalr_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.jalr) begin
            jalr_target <= redirect.target;  // captured in the stall cycle.
        end
    end

endmodule

`default_nettype wire

// ==== ifetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ifetch_top
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      bus_idle,
    input  logic      ar_ready,
    input  rd_resp_t  rd_resp,
    input  redirect_t redirect,
    input  logic      mem_stall,
    input  logic      md_start,
    input  logic      md_done,
    output logic      ar_valid,
    output bus_id_t   ar_id,
    output addr_t     ar_addr,
    output instr_t    instr,
    output logic      instr_valid,
    output addr_t     curr_pc
);

    logic fetch_done;
    logic md_hold;
    logic md_release;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // front end blocks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    muldiv_hold u_muldiv_hold (
        .clk        (clk),
        .rst_n      (rst_n),
        .md_start   (md_start),
        .md_done    (md_done),
        .fetch_done (fetch_done),
        .md_hold    (md_hold),
        .md_release (md_release)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_idle    (bus_idle),
        .ar_ready    (ar_ready),
        .rd_resp     (rd_resp),
        .curr_pc     (curr_pc),
        .ar_valid    (ar_valid),
        .ar_id       (ar_id),
        .ar_addr     (ar_addr),
        .instr       (instr),
        .instr_valid (instr_valid),
        .fetch_done  (fetch_done)
    );

    pc_gen u_pc_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .mem_stall  (mem_stall),
        .md_hold    (md_hold),
        .md_release (md_release),
        .fetch_done (fetch_done),
        .curr_pc    (curr_pc)
    );

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ar_valid,
    input  bus_id_t  ar_id,
    input  addr_t    ar_addr,
    input  logic     busy_req,
    input  int       latency,
    input  int       ready_delay,
    input  logic     foreign_req,
    output logic     ar_ready,
    output logic     bus_idle,
    output rd_resp_t rd_resp
);

    localparam instr_t  WORD_KEY   = 32'h1357_9BDF;
    localparam bus_id_t FOREIGN_ID = 4'd5;

    logic     ready_q   = 1'b0;
    logic     idle_q    = 1'b0;
    rd_resp_t resp_q    = '0;
    logic     pend      = 1'b0;
    int       wait_cnt  = 0;
    int       rdy_cnt   = 0;
    addr_t    pend_addr = '0;
    bus_id_t  pend_id   = '0;

    assign ar_ready = ready_q;
    assign bus_idle = idle_q;
    assign rd_resp  = resp_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port with back-pressure and latency.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q  <= 1'b0;
            idle_q   <= 1'b0;
            resp_q   <= '0;
            pend     <= 1'b0;
            wait_cnt <= 0;
            rdy_cnt  <= 0;
        end else begin
            idle_q <= !busy_req;    // the data side owns the bus while busy.
            resp_q <= '0;
            if (ar_valid && ready_q) begin
                ready_q   <= 1'b0;
                rdy_cnt   <= 0;
                pend      <= 1'b1;
                pend_addr <= ar_addr;
                pend_id   <= ar_id;
                wait_cnt  <= latency;
            end else if (ar_valid) begin
                if (rdy_cnt >= ready_delay) begin
                    ready_q <= 1'b1;
                end else begin
                    rdy_cnt <= rdy_cnt + 1;
                end
            end
            if (pend && (wait_cnt == 0)) begin
                resp_q <= {1'b1, pend_id, pend_addr ^ WORD_KEY};
                pend   <= 1'b0;
            end else begin
                if (pend) begin
                    wait_cnt <= wait_cnt - 1;
                end
                if (foreign_req) begin
                    resp_q <= {1'b1, FOREIGN_ID, 32'hDEAD_BEEF};  // a data read answer.
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_ifetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ifetch
    import core_pkg::*;
();

    localparam instr_t WORD_KEY  = 32'h1357_9BDF;
    localparam int     NUM_TESTS = 5;

    logic      clk;
    logic      rst_n;
    logic      bus_idle;
    logic      ar_ready;
    rd_resp_t  rd_resp;
    redirect_t redirect;
    logic      mem_stall;
    logic      md_start;
    logic      md_done;
    logic      ar_valid;
    bus_id_t   ar_id;
    addr_t     ar_addr;
    instr_t    instr;
    logic      instr_valid;
    addr_t     curr_pc;

    logic      busy_req;
    logic      force_busy;
    logic      gap_en;
    logic      foreign_req;
    int        latency;
    int        ready_delay;
    int        lat_min;
    int        lat_max;
    int        ready_max;
    int        seed;
    int        errors;
    int        checks;
    int        idle_run;
    logic      av_seen;
    addr_t     req_pc;
    addr_t     req_addr;

    addr_t     exp_pc;
    md_state_e ref_md;
    logic      ref_pend;
    addr_t     ref_tgt;
    logic      ref_hold;
    logic      ref_rel;
    logic      ref_fdone;

    ifetch_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_idle    (bus_idle),
        .ar_ready    (ar_ready),
        .rd_resp     (rd_resp),
        .redirect    (redirect),
        .mem_stall   (mem_stall),
        .md_start    (md_start),
        .md_done     (md_done),
        .ar_valid    (ar_valid),
        .ar_id       (ar_id),
        .ar_addr     (ar_addr),
        .instr       (instr),
        .instr_valid (instr_valid),
        .curr_pc     (curr_pc)
    );

    tb_mem_model mem0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .ar_valid    (ar_valid),
        .ar_id       (ar_id),
        .ar_addr     (ar_addr),
        .busy_req    (busy_req),
        .latency     (latency),
        .ready_delay (ready_delay),
        .foreign_req (foreign_req),
        .ar_ready    (ar_ready),
        .bus_idle    (bus_idle),
        .rd_resp     (rd_resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model of the pc.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic addr_t next_pc(addr_t pc, logic rel, logic hold, logic stall,
                                      redirect_t rd, logic pend, addr_t tgt, logic fdone);
        if (rel) return pc + 32'd4;
        if (hold || stall || rd.jalr) return pc;
        if (pend) return tgt;
        if (rd.taken) return rd.target;
        if (fdone) return pc + 32'd4;
        return pc;
    endfunction

    assign ref_hold = (ref_md == MD_BUSY) || (ref_md == MD_WAIT_FETCH);
    assign ref_rel  = (ref_md == MD_RELEASE);

    // a fetch completes in the cycle after its own response is seen on the bus.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc    <= 32'h8000_0000;
            ref_md    <= MD_IDLE;
            ref_pend  <= 1'b0;
            ref_tgt   <= '0;
            ref_fdone <= 1'b0;
        end else begin
            ref_fdone <= rd_resp.done && (rd_resp.id == FETCH_ID);
            exp_pc <= next_pc(exp_pc, ref_rel, ref_hold, mem_stall, redirect,
                              ref_pend, ref_tgt, ref_fdone);
            case (ref_md)
                MD_IDLE:       if (md_start) ref_md <= MD_BUSY;
                MD_BUSY:       if (md_done) ref_md <= ref_fdone ? MD_RELEASE : MD_WAIT_FETCH;
                MD_WAIT_FETCH: if (ref_fdone) ref_md <= MD_RELEASE;
                default:       ref_md <= MD_IDLE;
            endcase
            if (redirect.jalr) begin
                ref_pend <= 1'b1;
                ref_tgt  <= redirect.target;
            end else if (ref_pend && !ref_rel && !ref_hold && !mem_stall) begin
                ref_pend <= 1'b0;
            end
        end
    end

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitors.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        idle_run <= bus_idle ? idle_run + 1 : 0;
        req_pc   <= exp_pc;    // the pc that a request raised on this edge must carry.
        if (rst_n && ar_valid && ar_ready) begin
            check("ar_id", 32'(ar_id), 32'(FETCH_ID));
            check("ar_addr", ar_addr, req_addr);
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check("curr_pc", curr_pc, exp_pc);
            check("instr_valid", 32'(instr_valid), 32'(ref_fdone));
            if (ref_fdone) check("instr", instr, req_addr ^ WORD_KEY);
            if (ar_valid && !av_seen) begin
                check("quiet_before_ar_valid", 32'(idle_run >= 4), 32'd1);
                check("ar_addr", ar_addr, req_pc);
                req_addr = req_pc;
            end
        end
        av_seen = ar_valid;
    end

    // random latency, ready delay and bus gaps.
    always @(posedge clk) begin
        latency     <= lat_min + $unsigned($random(seed)) % lat_max;
        ready_delay <= $unsigned($random(seed)) % ready_max;
        busy_req    <= force_busy || (gap_en && (($unsigned($random(seed)) % 3) == 0));
    end

    task automatic wait_fetches(int n);
        int seen;
        int cyc;
        seen = 0;
        cyc  = 0;
        while (seen < n && cyc < 400) begin
            @(posedge clk);
            cyc++;
            if (instr_valid) seen++;
        end
        if (seen < n) begin
            errors++;
            $display("timed out at %0t waiting for %0d fetch responses", $time, n);
        end
    endtask

    task automatic pulse_redirect(logic taken, logic jalr, addr_t target);
        @(posedge clk);
        redirect <= {taken, jalr, target};
        @(posedge clk);
        redirect <= '0;
    endtask

    task automatic report_test(int num, string name, int errs_before);
        if (errors == errs_before) $display("test %0d %s: ok", num, name);
        else $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    endtask

    initial begin
        repeat (2000 * NUM_TESTS) @(posedge clk);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("Some tests failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int e0;
        addr_t pc_save;
        instr_t instr_save;
        seed = 14290;
        errors = 0;
        checks = 0;
        idle_run = 0;
        av_seen = 1'b0;
        req_addr = '0;
        rst_n = 1'b0;
        redirect = '0;
        mem_stall = 1'b0;
        md_start = 1'b0;
        md_done = 1'b0;
        busy_req = 1'b1;
        force_busy = 1'b1;
        gap_en = 1'b0;
        foreign_req = 1'b0;
        lat_min = 0;
        lat_max = 1;
        ready_max = 1;
        latency = 0;
        ready_delay = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        e0 = errors;
        repeat (20) begin
            @(negedge clk);
            check("ar_valid", 32'(ar_valid), 32'd0);
            check("instr_valid", 32'(instr_valid), 32'd0);
            check("instr", instr, 32'd0);
        end
        report_test(1, "reset values", e0);

        e0 = errors;
        @(posedge clk);
        force_busy <= 1'b0;
        lat_max <= 6;
        ready_max <= 4;
        wait_fetches(10);
        report_test(2, "sequential fetch", e0);

        e0 = errors;
        gap_en <= 1'b1;
        wait_fetches(6);
        gap_en <= 1'b0;
        lat_min <= 6;                  // the real answer comes well after the foreign one.
        while (!(ar_valid && ar_ready)) @(posedge clk);
        pc_save = curr_pc;
        instr_save = instr;
        foreign_req <= 1'b1;
        @(posedge clk);
        foreign_req <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check("instr", instr, instr_save);
            check("instr_valid", 32'(instr_valid), 32'd0);
            check("curr_pc", curr_pc, pc_save);
        end
        @(posedge clk);
        lat_min <= 0;
        wait_fetches(1);
        report_test(3, "quiet rule and id filter", e0);

        e0 = errors;
        pulse_redirect(1'b1, 1'b0, {$random(seed)} & 32'hFFFF_FFFC);
        repeat (3) @(posedge clk);
        pulse_redirect(1'b0, 1'b1, {$random(seed)} & 32'hFFFF_FFFC);
        repeat (4) @(posedge clk);
        mem_stall <= 1'b1;
        repeat (8) @(posedge clk);
        mem_stall <= 1'b0;
        wait_fetches(2);
        report_test(4, "redirects", e0);

        e0 = errors;
        md_start <= 1'b1;
        @(posedge clk);
        md_start <= 1'b0;
        @(posedge clk);
        md_done <= 1'b1;              // unit ends before the fetch.
        @(posedge clk);
        md_done <= 1'b0;
        wait_fetches(2);
        md_start <= 1'b1;
        @(posedge clk);
        md_start <= 1'b0;
        wait_fetches(2);
        md_done <= 1'b1;              // fetches end before the unit.
        @(posedge clk);
        md_done <= 1'b0;
        wait_fetches(2);
        report_test(5, "multiply/divide hold", e0);

        $display("tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
core_pkg.sv
muldiv_hold.sv
fetch_ctrl.sv
pc_gen.sv
ifetch_top.sv
tb_mem_model.sv
tb_ifetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the fetch front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -f sources.f --top-module tb_ifetch -o sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim > sim.log 2>&1
cat sim.log

grep -q "Some tests failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }

echo "simulation passed"
exit 0
